/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mem_access_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
+incdir+rtl
rtl/mem_access_pkg.sv
rtl/mem_req_if.sv
rtl/fetch_port.sv
rtl/data_port.sv
rtl/bus_arbiter.sv
rtl/mem_access_top.sv
verification/mem_access_assert.sv
verification/mem_access_tb.sv

/* rtl/bus_arbiter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed priority arbiter, data before fetch, driving a
// single beat valid/ready bus with an rvalid response
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
	import mem_access_pkg::*;
(
	input  logic aclk,
	input  logic rst,
	mem_req_if.server fetch_side,
	mem_req_if.server data_side,
	output logic bus_valid,
	output addr_t bus_addr,
	output logic bus_we,
	output strb_t bus_wstrb,
	output word_t bus_wdata,
	input  logic bus_ready,
	input  logic bus_rvalid,
	input  word_t bus_rdata
);

	arb_state_t state;
	logic       grant_data;
	logic       fetch_done_q;
	logic       data_done_q;
	word_t      rdata_q;
	logic       pick_data;
	logic       pick_fetch;

	// a side still in its done cycle has not dropped req yet
	assign pick_data = data_side.req && !data_done_q;
	assign pick_fetch = fetch_side.req && !fetch_done_q && !pick_data;

	assign fetch_side.done = fetch_done_q;
	assign data_side.done = data_done_q;
	assign fetch_side.rdata = rdata_q;
	assign data_side.rdata = rdata_q;

	always_ff @(posedge aclk) begin
		if (!rst) begin
			state <= ARB_IDLE;
			grant_data <= 1'b0;
			bus_valid <= 1'b0;
			fetch_done_q <= 1'b0;
			data_done_q <= 1'b0;
		end else begin
			fetch_done_q <= 1'b0;
			data_done_q <= 1'b0;
			case (state)
				ARB_IDLE: begin
					if (pick_data || pick_fetch) begin
						grant_data <= pick_data;
						bus_valid <= 1'b1;
						state <= ARB_ISSUE;
					end
				end
				ARB_ISSUE: begin
					if (bus_ready) begin
						bus_valid <= 1'b0;
						state <= ARB_WAIT;
					end
				end
				ARB_WAIT: begin
					if (bus_rvalid) begin
						data_done_q <= grant_data;
						fetch_done_q <= !grant_data;
						state <= ARB_IDLE;
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// bus fields only load when a new grant is made
	always_ff @(posedge aclk) begin
		if (state == ARB_IDLE && (pick_data || pick_fetch)) begin
			bus_addr <= pick_data ? data_side.addr : fetch_side.addr;
			bus_we <= pick_data ? data_side.we : fetch_side.we;
			bus_wstrb <= pick_data ? data_side.wstrb : fetch_side.wstrb;
			bus_wdata <= pick_data ? data_side.wdata : fetch_side.wdata;
		end
		if (state == ARB_WAIT && bus_rvalid) begin
			rdata_q <= bus_rdata;
		end
	end

endmodule

`default_nettype wire

/* rtl/data_port.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store port: alignment check, byte strobes and lane
// replication for stores, sign/zero extension for loads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "mem_access_params.svh"

module data_port
	import mem_access_pkg::*;
(
	input  logic aclk,
	input  logic rst,
	input  logic data_req,
	input  ls_op_t data_op,
	input  addr_t data_addr,
	input  word_t data_wdata,
	output logic data_ready,
	output logic data_done,
	output logic data_fault,
	output word_t data_rdata,
	mem_req_if.requester bus
);

	logic       busy;
	logic       req_q;
	logic       fault_q;
	logic       we_q;
	addr_t      addr_q;
	strb_t      strb_q;
	word_t      wdata_q;
	ls_op_t     op_q;
	logic [1:0] off_q;
	word_t      rdata_q;
	word_t      ld_val;
	logic       accept;
	logic       misaligned;
	logic       is_store;
	strb_t      strb_d;
	word_t      wdata_d;
	addr_t      phys;

	// little endian lane select, stores give zero
	function automatic word_t load_extend(ls_op_t op, logic [1:0] off, word_t w);
		word_t sh;
		sh = w >> {off, 3'b000};
		case (op)
			`MA_OP_LB:  return {{(`MA_DATA_W-8){sh[7]}}, sh[7:0]};
			`MA_OP_LBU: return {{(`MA_DATA_W-8){1'b0}}, sh[7:0]};
			`MA_OP_LH:  return {{(`MA_DATA_W-16){sh[15]}}, sh[15:0]};
			`MA_OP_LHU: return {{(`MA_DATA_W-16){1'b0}}, sh[15:0]};
			`MA_OP_LW:  return w;
			default:    return '0;
		endcase
	endfunction

	assign accept = data_req && data_ready;
	assign phys = to_physical(data_addr);

	always_comb begin
		misaligned = 1'b0;
		is_store = 1'b0;
		strb_d = '0;
		wdata_d = data_wdata;
		case (data_op)
			`MA_OP_LH, `MA_OP_LHU: begin
				misaligned = data_addr[0];
			end
			`MA_OP_LW: begin
				misaligned = |data_addr[1:0];
			end
			`MA_OP_SB: begin
				is_store = 1'b1;
				strb_d = strb_t'(1) << data_addr[1:0];
				wdata_d = {4{data_wdata[7:0]}};
			end
			`MA_OP_SH: begin
				misaligned = data_addr[0];
				is_store = 1'b1;
				strb_d = data_addr[1] ? 4'b1100 : 4'b0011;
				wdata_d = {2{data_wdata[15:0]}};
			end
			`MA_OP_SW: begin
				misaligned = |data_addr[1:0];
				is_store = 1'b1;
				strb_d = 4'b1111;
			end
			default: begin
				misaligned = 1'b0;
			end
		endcase
	end

	assign ld_val = load_extend(op_q, off_q, bus.rdata);

	assign data_ready = !busy;
	assign data_done = fault_q || bus.done;
	assign data_fault = fault_q;
	assign data_rdata = bus.done ? ld_val : rdata_q;

	assign bus.req = req_q;
	assign bus.addr = addr_q;
	assign bus.we = we_q;
	assign bus.wstrb = strb_q;
	assign bus.wdata = wdata_q;

	always_ff @(posedge aclk) begin
		if (!rst) begin
			busy <= 1'b0;
			req_q <= 1'b0;
			fault_q <= 1'b0;
		end else begin
			fault_q <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				fault_q <= misaligned;
				req_q <= !misaligned;
			end else if (data_done) begin
				busy <= 1'b0;
				req_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (accept) begin
			addr_q <= {phys[31:2], 2'b00};
			we_q <= is_store;
			strb_q <= strb_d;
			wdata_q <= wdata_d;
			op_q <= data_op;
			off_q <= data_addr[1:0];
		end
		if (accept && misaligned) begin
			rdata_q <= '0;
		end else if (bus.done) begin
			rdata_q <= ld_val;
		end
	end

endmodule

`default_nettype wire

/* rtl/fetch_port.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction fetch port: takes one word fetch at a time,
// faults on unaligned addresses, otherwise reads via arbiter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fetch_port
	import mem_access_pkg::*;
(
	input  logic aclk,
	input  logic rst,
	input  logic fetch_req,
	input  addr_t fetch_addr,
	output logic fetch_ready,
	output logic fetch_done,
	output logic fetch_fault,
	output word_t fetch_data,
	mem_req_if.requester bus
);

	logic  busy;
	logic  req_q;
	logic  fault_q;
	addr_t addr_q;
	word_t data_q;
	logic  accept;
	logic  misaligned;
	addr_t phys;

	assign accept = fetch_req && fetch_ready;
	assign misaligned = |fetch_addr[1:0];
	assign phys = to_physical(fetch_addr);

	assign fetch_ready = !busy;
	assign fetch_done = fault_q || bus.done;
	assign fetch_fault = fault_q;
	// word is visible in the done cycle, held afterwards
	assign fetch_data = bus.done ? bus.rdata : data_q;

	// fetches are always word reads
	assign bus.req = req_q;
	assign bus.addr = addr_q;
	assign bus.we = 1'b0;
	assign bus.wstrb = '0;
	assign bus.wdata = '0;

	always_ff @(posedge aclk) begin
		if (!rst) begin
			busy <= 1'b0;
			req_q <= 1'b0;
			fault_q <= 1'b0;
		end else begin
			fault_q <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				fault_q <= misaligned;
				req_q <= !misaligned;
			end else if (fetch_done) begin
				busy <= 1'b0;
				req_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (accept) begin
			addr_q <= {phys[31:2], 2'b00};
		end
		if (accept && misaligned) begin
			data_q <= '0;
		end else if (bus.done) begin
			data_q <= bus.rdata;
		end
	end

endmodule

`default_nettype wire

/* rtl/mem_access_params.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, address regions and load/store codes of the
// memory access unit, included by the package and the RTL
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MEM_ACCESS_PARAMS_SVH
`define MEM_ACCESS_PARAMS_SVH

`define MA_ADDR_W     32
`define MA_DATA_W     32
`define MA_STRB_W     4

// kseg0 and kseg1, both unmapped
`define MA_KSEG_LO    32'h8000_0000
`define MA_KSEG_HI    32'hBFFF_FFFF
`define MA_PHYS_MASK  32'h1FFF_FFFF

`define MA_OP_W       3
`define MA_OP_LB      3'd0
`define MA_OP_LBU     3'd1
`define MA_OP_LH      3'd2
`define MA_OP_LHU     3'd3
`define MA_OP_LW      3'd4
`define MA_OP_SB      3'd5
`define MA_OP_SH      3'd6
`define MA_OP_SW      3'd7

`endif

/* rtl/mem_access_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types and the virtual to physical mapping shared by the
// memory access unit, imported with a wildcard
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mem_access_params.svh"

package mem_access_pkg;

	typedef logic [`MA_ADDR_W-1:0] addr_t;
	typedef logic [`MA_DATA_W-1:0] word_t;
	typedef logic [`MA_STRB_W-1:0] strb_t;
	typedef logic [`MA_OP_W-1:0]   ls_op_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_ISSUE,
		ARB_WAIT
	} arb_state_t;

	// kseg0/kseg1 fold onto the low 512MB
	function automatic addr_t to_physical(addr_t va);
		if (va >= `MA_KSEG_LO && va <= `MA_KSEG_HI) begin
			return va & `MA_PHYS_MASK;
		end
		return va;
	endfunction

endpackage

`default_nettype wire

/* rtl/mem_access_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory access unit top: fetch and data ports sharing one
// external bus through the arbiter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mem_access_top
	import mem_access_pkg::*;
(
	input  logic aclk,
	input  logic rst,
	// fetch side
	input  logic fetch_req,
	input  addr_t fetch_addr,
	output logic fetch_ready,
	output logic fetch_done,
	output logic fetch_fault,
	output word_t fetch_data,
	// data side
	input  logic data_req,
	input  ls_op_t data_op,
	input  addr_t data_addr,
	input  word_t data_wdata,
	output logic data_ready,
	output logic data_done,
	output logic data_fault,
	output word_t data_rdata,
	// external bus
	output logic bus_valid,
	output addr_t bus_addr,
	output logic bus_we,
	output strb_t bus_wstrb,
	output word_t bus_wdata,
	input  logic bus_ready,
	input  logic bus_rvalid,
	input  word_t bus_rdata
);

	mem_req_if fetch_bus ();
	mem_req_if data_bus ();

	fetch_port i_fetch_port (
		.aclk        (aclk),
		.rst         (rst),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.fetch_ready (fetch_ready),
		.fetch_done  (fetch_done),
		.fetch_fault (fetch_fault),
		.fetch_data  (fetch_data),
		.bus         (fetch_bus.requester)
	);

	data_port i_data_port (
		.aclk       (aclk),
		.rst        (rst),
		.data_req   (data_req),
		.data_op    (data_op),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.data_ready (data_ready),
		.data_done  (data_done),
		.data_fault (data_fault),
		.data_rdata (data_rdata),
		.bus        (data_bus.requester)
	);

	bus_arbiter i_bus_arbiter (
		.aclk       (aclk),
		.rst        (rst),
		.fetch_side (fetch_bus.server),
		.data_side  (data_bus.server),
		.bus_valid  (bus_valid),
		.bus_addr   (bus_addr),
		.bus_we     (bus_we),
		.bus_wstrb  (bus_wstrb),
		.bus_wdata  (bus_wdata),
		.bus_ready  (bus_ready),
		.bus_rvalid (bus_rvalid),
		.bus_rdata  (bus_rdata)
	);

endmodule

`default_nettype wire

/* rtl/mem_req_if.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request/response link between one port and the arbiter
// port holds req and fields until a one cycle done pulse
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if import mem_access_pkg::*; ();

	logic  req;
	addr_t addr;
	logic  we;
	strb_t wstrb;
	word_t wdata;
	logic  done;
	word_t rdata;

	modport requester (
		output req, addr, we, wstrb, wdata,
		input  done, rdata
	);

	modport server (
		input  req, addr, we, wstrb, wdata,
		output done, rdata
	);

endinterface

`default_nettype wire

/* verification/mem_access_assert.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus protocol checks for the arbiter, attached with bind
// holds a count of failed assertions for the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mem_access_assert
	import mem_access_pkg::*;
(
	input logic  aclk,
	input logic  rst,
	input logic  bus_valid,
	input logic  bus_ready,
	input addr_t bus_addr,
	input logic  bus_we,
	input strb_t bus_wstrb,
	input word_t bus_wdata,
	input logic  fetch_req,
	input logic  data_req,
	input logic  fetch_done,
	input logic  data_done
);

	int fail_count = 0;

	// stalled request must not change
	a_hold: assert property (@(posedge aclk) disable iff (!rst)
		(bus_valid && !bus_ready) |=> (bus_valid && $stable(bus_addr) && $stable(bus_we)
			&& $stable(bus_wstrb) && $stable(bus_wdata)))
		else begin
			fail_count++;
			$error("bus request changed while bus_ready was low");
		end

	// done goes to one side only, and only to a side that requests
	a_one_done: assert property (@(posedge aclk) disable iff (!rst)
		!(fetch_done && data_done) && (!fetch_done || fetch_req)
			&& (!data_done || data_req))
		else begin
			fail_count++;
			$error("done raised on both sides or on a side without a request");
		end

	a_reset: assert property (@(posedge aclk) !rst |=> !bus_valid)
		else begin
			fail_count++;
			$error("bus_valid high after reset");
		end

endmodule

bind bus_arbiter mem_access_assert i_assert (
	.aclk       (aclk),
	.rst        (rst),
	.bus_valid  (bus_valid),
	.bus_ready  (bus_ready),
	.bus_addr   (bus_addr),
	.bus_we     (bus_we),
	.bus_wstrb  (bus_wstrb),
	.bus_wdata  (bus_wdata),
	.fetch_req  (fetch_side.req),
	.data_req   (data_side.req),
	.fetch_done (fetch_done_q),
	.data_done  (data_done_q)
);

`default_nettype wire

/* verification/mem_access_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the memory access unit: table driven fetch and
// load/store requests against a bus memory with random stalls
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "mem_access_params.svh"

module mem_access_tb import mem_access_pkg::*; ();

	localparam int MAX_ROWS = 40;

	logic   aclk;
	logic   rst;
	logic   fetch_req, fetch_ready, fetch_done, fetch_fault;
	addr_t  fetch_addr;
	word_t  fetch_data;
	logic   data_req, data_ready, data_done, data_fault;
	ls_op_t data_op;
	addr_t  data_addr;
	word_t  data_wdata, data_rdata;
	logic   bus_valid, bus_we, bus_ready, bus_rvalid;
	addr_t  bus_addr;
	strb_t  bus_wstrb;
	word_t  bus_wdata, bus_rdata;

	word_t  mem [256];
	word_t  model_mem [256];
	addr_t  tx_addr [64];
	int     tx_count;
	integer seed = 32'h887704df;
	int     rnd;
	logic [7:0] widx;
	word_t  rdata_next;

	logic   t_freq [MAX_ROWS];
	addr_t  t_faddr [MAX_ROWS];
	logic   t_dreq [MAX_ROWS];
	ls_op_t t_op [MAX_ROWS];
	addr_t  t_daddr [MAX_ROWS];
	word_t  t_wdata [MAX_ROWS];
	word_t  t_exp_data [MAX_ROWS];
	logic   t_exp_fault [MAX_ROWS];
	word_t  t_exp_fdata [MAX_ROWS];
	logic   t_exp_ffault [MAX_ROWS];
	int     n_rows = 0;
	logic   table_built = 1'b0;
	int     errors = 0;
	int     tests_ok = 0;
	int     tests_bad = 0;
	int     cycles;

	mem_access_top i_dut (.*);

	function automatic word_t fill_word(input int i);
		return {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'h31, i[7:0]};
	endfunction

	// kseg0 and kseg1 both drop the top three bits
	function automatic addr_t phys_of(input addr_t va);
		return (va[31:30] == 2'b10) ? {3'b000, va[28:0]} : va;
	endfunction

	function automatic logic fault_of(input ls_op_t op, input addr_t va);
		case (op)
			`MA_OP_LH, `MA_OP_LHU, `MA_OP_SH: return va[0];
			`MA_OP_LW, `MA_OP_SW: return va[1:0] != 2'b00;
			default: return 1'b0;
		endcase
	endfunction

	function automatic word_t load_of(input ls_op_t op, input logic [1:0] off, input word_t w);
		logic [7:0]  b;
		logic [15:0] h;
		b = w[{off, 3'b000} +: 8];
		h = off[1] ? w[31:16] : w[15:0];
		case (op)
			`MA_OP_LB:  return {{24{b[7]}}, b};
			`MA_OP_LBU: return {24'h0, b};
			`MA_OP_LH:  return {{16{h[15]}}, h};
			`MA_OP_LHU: return {16'h0, h};
			default:    return w;
		endcase
	endfunction

	// expected values come from the shadow word model, data before fetch
	task automatic add_row(input logic f_req, input addr_t f_addr, input logic d_req,
			input ls_op_t op, input addr_t d_addr, input word_t wdata);
		addr_t pa;
		addr_t fpa;
		pa = phys_of(d_addr);
		t_freq[n_rows] = f_req;
		t_faddr[n_rows] = f_addr;
		t_dreq[n_rows] = d_req;
		t_op[n_rows] = op;
		t_daddr[n_rows] = d_addr;
		t_wdata[n_rows] = wdata;
		t_exp_data[n_rows] = '0;
		t_exp_fault[n_rows] = d_req && fault_of(op, d_addr);
		if (d_req && !t_exp_fault[n_rows]) begin
			case (op)
				`MA_OP_SB: model_mem[pa[9:2]][{pa[1:0], 3'b000} +: 8] = wdata[7:0];
				`MA_OP_SH: model_mem[pa[9:2]][{pa[1], 4'b0000} +: 16] = wdata[15:0];
				`MA_OP_SW: model_mem[pa[9:2]] = wdata;
				default: t_exp_data[n_rows] = load_of(op, pa[1:0], model_mem[pa[9:2]]);
			endcase
		end
		fpa = phys_of(f_addr);
		t_exp_ffault[n_rows] = f_req && (f_addr[1:0] != 2'b00);
		t_exp_fdata[n_rows] = model_mem[fpa[9:2]];
		n_rows++;
	endtask

	task automatic note_mismatch(input string name, input word_t exp, input word_t act);
		$display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
		errors++;
	endtask

	task automatic run_row(input int r);
		int    wait_cycles;
		int    tx_before;
		int    errors_before;
		logic  f_pend;
		logic  d_pend;
		addr_t pa;
		errors_before = errors;
		tx_before = tx_count;
		fetch_req <= t_freq[r];
		fetch_addr <= t_faddr[r];
		data_req <= t_dreq[r];
		data_op <= t_op[r];
		data_addr <= t_daddr[r];
		data_wdata <= t_wdata[r];
		@(posedge aclk);
		if ((t_freq[r] && !fetch_ready) || (t_dreq[r] && !data_ready)) begin
			$display("error at %0t: row %0d request was not accepted", $time, r);
			errors++;
		end
		fetch_req <= 1'b0;
		data_req <= 1'b0;
		f_pend = t_freq[r];
		d_pend = t_dreq[r];
		wait_cycles = 0;
		while (f_pend || d_pend) begin
			@(posedge aclk);
			wait_cycles++;
			if ((f_pend && fetch_ready) || (d_pend && data_ready)) begin
				$display("error at %0t: ready high while a request is pending", $time);
				errors++;
			end
			if (f_pend && fetch_done) begin
				f_pend = 1'b0;
				if (fetch_fault !== t_exp_ffault[r])
					note_mismatch("fetch_fault", word_t'(t_exp_ffault[r]), word_t'(fetch_fault));
				if (!t_exp_ffault[r] && fetch_data !== t_exp_fdata[r])
					note_mismatch("fetch_data", t_exp_fdata[r], fetch_data);
				if (t_exp_ffault[r] && wait_cycles != 1) begin
					$display("error at %0t: fetch fault was not one cycle after acceptance", $time);
					errors++;
				end
			end
			if (d_pend && data_done) begin
				d_pend = 1'b0;
				if (data_fault !== t_exp_fault[r])
					note_mismatch("data_fault", word_t'(t_exp_fault[r]), word_t'(data_fault));
				if (!t_exp_fault[r] && data_rdata !== t_exp_data[r])
					note_mismatch("data_rdata", t_exp_data[r], data_rdata);
				if (t_exp_fault[r] && wait_cycles != 1) begin
					$display("error at %0t: data fault was not one cycle after acceptance", $time);
					errors++;
				end
			end
		end
		// faulted requests never reach the bus, ports free again right after
		if ((!t_freq[r] || t_exp_ffault[r]) && (!t_dreq[r] || t_exp_fault[r])) begin
			for (int i = 0; i < 2; i++) begin
				@(posedge aclk);
				if (i == 0 && (fetch_ready !== 1'b1 || data_ready !== 1'b1)) begin
					$display("error at %0t: port not ready in the cycle after a fault", $time);
					errors++;
				end
				if (bus_valid !== 1'b0) begin
					$display("error at %0t: bus_valid raised after a faulted request", $time);
					errors++;
				end
			end
			if (tx_count != tx_before)
				note_mismatch("bus transaction count", word_t'(tx_before), word_t'(tx_count));
		end
		pa = phys_of(t_daddr[r]);
		if (t_freq[r] && t_dreq[r] && !t_exp_ffault[r] && !t_exp_fault[r]
				&& tx_addr[tx_before] !== {pa[31:2], 2'b00})
			note_mismatch("first bus_addr", {pa[31:2], 2'b00}, tx_addr[tx_before]);
		$display("row %0d: %s", r, (errors == errors_before) ? "ok" : "failed");
		if (errors == errors_before)
			tests_ok++;
		else
			tests_bad++;
	endtask

	initial begin
		aclk = 1'b0;
		forever #10 aclk = ~aclk;
	end

	// bus memory with 0 to 3 cycle stalls before ready and rvalid
	initial begin
		bus_ready <= 1'b0;
		bus_rvalid <= 1'b0;
		bus_rdata <= '0;
		tx_count = 0;
		for (int i = 0; i < 256; i++)
			mem[i] = fill_word(i);
		forever begin
			@(posedge aclk);
			if (bus_valid) begin
				rnd = $random(seed);
				repeat (rnd[1:0]) @(posedge aclk);
				bus_ready <= 1'b1;
				@(posedge aclk);
				bus_ready <= 1'b0;
				widx = bus_addr[9:2];
				tx_addr[tx_count] = bus_addr;
				tx_count++;
				for (int i = 0; i < 4; i++)
					if (bus_we && bus_wstrb[i])
						mem[widx][8*i +: 8] = bus_wdata[8*i +: 8];
				rdata_next = bus_we ? '0 : mem[widx];
				rnd = $random(seed);
				repeat (rnd[1:0]) @(posedge aclk);
				bus_rvalid <= 1'b1;
				bus_rdata <= rdata_next;
				@(posedge aclk);
				bus_rvalid <= 1'b0;
			end
		end
	end

	initial begin
		cycles = 0;
		wait (table_built);
		while (cycles < n_rows * 20) begin
			@(posedge aclk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		rst <= 1'b0;
		fetch_req <= 1'b0;
		fetch_addr <= '0;
		data_req <= 1'b0;
		data_op <= `MA_OP_LW;
		data_addr <= '0;
		data_wdata <= '0;
		for (int i = 0; i < 256; i++)
			model_mem[i] = fill_word(i);
		// kseg1 store, kuseg load and kseg0 fetch of one word
		add_row(1'b0, 32'h0, 1'b1, `MA_OP_SW, 32'hA000_0040, 32'h1234_5678);
		add_row(1'b0, 32'h0, 1'b1, `MA_OP_LW, 32'h0000_0040, 32'h0);
		add_row(1'b1, 32'h8000_0040, 1'b0, `MA_OP_LW, 32'h0, 32'h0);
		// byte and half merges, then every extension at every offset
		add_row(1'b0, 32'h0, 1'b1, `MA_OP_SW, 32'h8000_0080, 32'h1122_3344);
		add_row(1'b0, 32'h0, 1'b1, `MA_OP_SB, 32'hA000_0081, 32'hDEAD_BE9A);
		add_row(1'b0, 32'h0, 1'b1, `MA_OP_SH, 32'hA000_0082, 32'h0000_80F1);
		add_row(1'b0, 32'h0, 1'b1, `MA_OP_SB, 32'h0000_0080, 32'h0000_007F);
		for (int i = 0; i < 4; i++) begin
			add_row(1'b0, 32'h0, 1'b1, `MA_OP_LB, 32'h8000_0080 + i, 32'h0);
			add_row(1'b0, 32'h0, 1'b1, `MA_OP_LBU, 32'h0000_0080 + i, 32'h0);
		end
		for (int i = 0; i < 2; i++) begin
			add_row(1'b0, 32'h0, 1'b1, `MA_OP_LH, 32'hA000_0080 + 2 * i, 32'h0);
			add_row(1'b0, 32'h0, 1'b1, `MA_OP_LHU, 32'h0000_0080 + 2 * i, 32'h0);
		end
		add_row(1'b0, 32'h0, 1'b1, `MA_OP_LW, 32'h0000_0080, 32'h0);
		// misaligned requests
		add_row(1'b0, 32'h0, 1'b1, `MA_OP_LH, 32'h0000_0081, 32'h0);
		add_row(1'b0, 32'h0, 1'b1, `MA_OP_LHU, 32'h0000_0083, 32'h0);
		add_row(1'b0, 32'h0, 1'b1, `MA_OP_SH, 32'h0000_0083, 32'hFFFF_FFFF);
		for (int i = 1; i < 4; i++) begin
			add_row(1'b0, 32'h0, 1'b1, `MA_OP_LW, 32'h0000_0080 + i, 32'h0);
			add_row(1'b0, 32'h0, 1'b1, `MA_OP_SW, 32'hA000_0084 + i, 32'hBAD0_BAD0);
		end
		add_row(1'b1, 32'h8000_0042, 1'b0, `MA_OP_LW, 32'h0, 32'h0);
		add_row(1'b0, 32'h0, 1'b1, `MA_OP_LW, 32'h0000_0084, 32'h0);
		// fetch and data in the same cycle
		add_row(1'b1, 32'h0000_0040, 1'b1, `MA_OP_LW, 32'h8000_0080, 32'h0);
		add_row(1'b1, 32'h8000_0100, 1'b1, `MA_OP_SW, 32'hA000_0100, 32'h55AA_33CC);
		table_built = 1'b1;
		repeat (3) @(posedge aclk);
		rst <= 1'b1;
		@(posedge aclk);
		if (fetch_ready !== 1'b1)
			note_mismatch("fetch_ready", 32'd1, word_t'(fetch_ready));
		if (data_ready !== 1'b1)
			note_mismatch("data_ready", 32'd1, word_t'(data_ready));
		if (fetch_done !== 1'b0)
			note_mismatch("fetch_done", 32'd0, word_t'(fetch_done));
		if (data_done !== 1'b0)
			note_mismatch("data_done", 32'd0, word_t'(data_done));
		if (fetch_fault !== 1'b0)
			note_mismatch("fetch_fault", 32'd0, word_t'(fetch_fault));
		if (data_fault !== 1'b0)
			note_mismatch("data_fault", 32'd0, word_t'(data_fault));
		if (bus_valid !== 1'b0)
			note_mismatch("bus_valid", 32'd0, word_t'(bus_valid));
		if (errors == 0)
			tests_ok++;
		else
			tests_bad++;
		$display("reset state: %s", (errors == 0) ? "ok" : "failed");
		for (int r = 0; r < n_rows; r++)
			run_row(r);
		$display("tests passed %0d, failed %0d, assertion errors %0d", tests_ok, tests_bad,
			i_dut.i_bus_arbiter.i_assert.fail_count);
		if (errors == 0 && i_dut.i_bus_arbiter.i_assert.fail_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
